// File: design/encoder_pkg.sv
package encoder_pkg;

	// Channel count and the width of a channel index.
	localparam int NUM_CH = 2;
	localparam int CH_BITS = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	// AS5311 serial frame, 12 position or status bits plus flags and parity.
	localparam int SAMPLE_BITS = 18;
	localparam int BIT_CNT_BITS = $clog2(SAMPLE_BITS + 1);

	// Serial clock divider width.
	localparam int DIV_BITS = 12;

	// Host command and response codes.
	localparam int CMD_BITS = 8;
	localparam logic [CMD_BITS-1:0] CMD_CONFIG_ENCODER = 8'h40;
	localparam logic [31:0] RSP_ENCODER_DATA = 32'h0000_0041;

	typedef logic [CH_BITS-1:0] ch_idx_t;

	typedef logic [SAMPLE_BITS-1:0] sample_t;

	// Encoded as sent in the kind word of a report.
	typedef enum logic {
		KIND_MAGNET = 1'b0,
		KIND_POSITION = 1'b1
	} frame_kind_t;

	typedef logic [DIV_BITS-1:0] div_t;

endpackage

// File: design/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
	input logic clk,
	input logic reset,
	input logic [31:0] systime,
	input logic [31:0] arg_data,
	input logic [encoder_pkg::CMD_BITS-1:0] cmd,
	input logic cmd_ready,
	output logic cfg_write,
	output encoder_pkg::ch_idx_t cfg_ch,
	output encoder_pkg::div_t cfg_div,
	output logic [31:0] cfg_data_int,
	output logic [31:0] cfg_mag_int,
	output logic [31:0] cfg_time,
	output logic cfg_done,
	output logic decode_busy
);
	import encoder_pkg::*;

	// One state per argument word still to come.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DIV,
		ST_DATA_INT,
		ST_MAG_INT
	} state_t;

	state_t state;
	logic busy_q;

	assign busy_q = (state != ST_IDLE) || cfg_done;

	// Busy from the command strobe up to and including the done pulse.
	assign decode_busy = cmd_ready || busy_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cfg_write <= 1'b0;
			cfg_done <= 1'b0;
		end else begin
			cfg_write <= 1'b0;
			cfg_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd_ready) begin
						if (cmd == CMD_CONFIG_ENCODER) begin
							state <= ST_DIV;
						end else begin
							cfg_done <= 1'b1;
						end
					end
				end
				ST_DIV: begin
					state <= ST_DATA_INT;
				end
				ST_DATA_INT: begin
					state <= ST_MAG_INT;
				end
				ST_MAG_INT: begin
					cfg_write <= 1'b1;
					cfg_done <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd_ready) begin
			cfg_ch <= arg_data[CH_BITS-1:0];
		end
		if (state == ST_DIV) begin
			cfg_div <= arg_data[DIV_BITS-1:0];
		end
		// Both schedules start from the time of the data interval word.
		if (state == ST_DATA_INT) begin
			cfg_data_int <= arg_data;
			cfg_time <= systime;
		end
		if (state == ST_MAG_INT) begin
			cfg_mag_int <= arg_data;
		end
	end

	// The host waits for cmd_done before it issues the next command.
	a_no_cmd_while_busy: assert property (
		@(posedge clk) disable iff (reset) cmd_ready |-> !busy_q
	) else $error("cmd_decode: command strobe while a command is in progress");

endmodule

// File: design/ssi_reader.sv
`timescale 1ns/1ps

module ssi_reader #(
	parameter encoder_pkg::ch_idx_t CH = '0
) (
	input logic clk,
	input logic reset,
	input logic [31:0] systime,
	input logic cfg_write,
	input encoder_pkg::ch_idx_t cfg_ch,
	input encoder_pkg::div_t cfg_div,
	input logic [31:0] cfg_data_int,
	input logic [31:0] cfg_mag_int,
	input logic [31:0] cfg_time,
	input logic enc_do,
	output logic enc_clk,
	output logic enc_cs,
	output logic frame_valid,
	output encoder_pkg::sample_t frame_value,
	output encoder_pkg::frame_kind_t frame_kind,
	output logic [31:0] frame_start,
	input logic frame_ack
);
	import encoder_pkg::*;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CS_LO,
		PH_CLK_LO,
		PH_CLK_HI,
		PH_CS_HI,
		PH_END
	} phase_t;

	phase_t phase;
	div_t div_cfg;
	div_t div_cnt;
	logic [31:0] data_int;
	logic [31:0] mag_int;
	logic [31:0] next_data;
	logic [31:0] next_mag;
	logic data_pending;
	logic mag_pending;
	logic [BIT_CNT_BITS-1:0] bit_cnt;
	sample_t shift;
	sample_t prev_pos;
	sample_t prev_mag;
	frame_kind_t cur_kind;
	logic [31:0] cur_start;
	logic enabled;
	logic cfg_hit;
	logic data_due;
	logic mag_due;
	logic phase_end;
	logic start;
	logic shift_en;
	logic last_bit;
	logic capture;
	logic changed;

	assign enabled = (div_cfg != '0);
	assign cfg_hit = cfg_write && (cfg_ch == CH);
	assign data_due = (data_int != '0) && (systime == next_data);
	assign mag_due = (mag_int != '0) && (systime == next_mag);
	assign phase_end = (div_cnt == div_t'(1));
	assign start = enabled && (phase == PH_IDLE) && (data_pending || mag_pending);
	assign shift_en = enabled && (phase == PH_CLK_LO) && phase_end;
	assign last_bit = (bit_cnt == BIT_CNT_BITS'(SAMPLE_BITS));
	assign capture = enabled && (phase == PH_CLK_HI) && phase_end && last_bit;

	// Position and magnet frames each have their own change filter.
	assign changed = (cur_kind == KIND_POSITION) ? (shift != prev_pos) : (shift != prev_mag);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			enc_clk <= 1'b1;
			enc_cs <= 1'b1;
			div_cfg <= '0;
			div_cnt <= '0;
			data_int <= '0;
			mag_int <= '0;
			data_pending <= 1'b0;
			mag_pending <= 1'b0;
			bit_cnt <= '0;
			frame_valid <= 1'b0;
			prev_pos <= '1;
			prev_mag <= '1;
		end else begin
			if (frame_ack) begin
				frame_valid <= 1'b0;
			end

			if (!enabled) begin
				phase <= PH_IDLE;
				enc_clk <= 1'b1;
				enc_cs <= 1'b1;
			end else if (phase == PH_IDLE) begin
				if (start) begin
					enc_cs <= 1'b0;
					div_cnt <= div_cfg;
					bit_cnt <= '0;
					phase <= PH_CS_LO;
					// Position wins when both kinds are due.
					if (data_pending) begin
						data_pending <= 1'b0;
					end else begin
						mag_pending <= 1'b0;
					end
				end
			end else if (!phase_end) begin
				div_cnt <= div_cnt - 1'b1;
			end else begin
				div_cnt <= div_cfg;
				case (phase)
					PH_CS_LO: begin
						enc_clk <= 1'b0;
						phase <= PH_CLK_LO;
					end
					PH_CLK_LO: begin
						enc_clk <= 1'b1;
						bit_cnt <= bit_cnt + 1'b1;
						phase <= PH_CLK_HI;
					end
					PH_CLK_HI: begin
						if (last_bit) begin
							enc_cs <= 1'b1;
							phase <= PH_CS_HI;
						end else begin
							enc_clk <= 1'b0;
							phase <= PH_CLK_LO;
						end
					end
					PH_CS_HI: begin
						phase <= PH_END;
					end
					default: begin
						phase <= PH_IDLE;
					end
				endcase
			end

			if (capture && changed) begin
				frame_valid <= 1'b1;
				if (cur_kind == KIND_POSITION) begin
					prev_pos <= shift;
				end else begin
					prev_mag <= shift;
				end
			end

			// A due time only sets the flag, so a busy frame delays it.
			if (data_due) begin
				data_pending <= 1'b1;
			end
			if (mag_due) begin
				mag_pending <= 1'b1;
			end

			if (cfg_hit) begin
				div_cfg <= cfg_div;
				data_int <= cfg_data_int;
				mag_int <= cfg_mag_int;
				data_pending <= 1'b0;
				mag_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cur_kind <= data_pending ? KIND_POSITION : KIND_MAGNET;
			cur_start <= systime;
		end
		// Sensor data is taken as enc_clk rises, MSB first.
		if (shift_en) begin
			shift <= {shift[SAMPLE_BITS-2:0], enc_do};
		end
		if (cfg_hit) begin
			next_data <= cfg_time + cfg_data_int;
			next_mag <= cfg_time + cfg_mag_int;
		end else begin
			if (data_due) begin
				next_data <= next_data + data_int;
			end
			if (mag_due) begin
				next_mag <= next_mag + mag_int;
			end
		end
		if (capture && changed) begin
			frame_value <= shift;
			frame_kind <= cur_kind;
			frame_start <= cur_start;
		end
	end

	a_cs_high_when_idle: assert property (
		@(posedge clk) disable iff (reset) (phase == PH_IDLE) |-> enc_cs
	) else $error("ssi_reader: chip select low while idle");

	a_bit_count_range: assert property (
		@(posedge clk) disable iff (reset) bit_cnt <= BIT_CNT_BITS'(SAMPLE_BITS)
	) else $error("ssi_reader: bit count past frame length");

endmodule

// File: design/report_framer.sv
`timescale 1ns/1ps

module report_framer (
	input logic clk,
	input logic reset,
	input logic [encoder_pkg::NUM_CH-1:0] frame_valid,
	input encoder_pkg::sample_t frame_value [encoder_pkg::NUM_CH],
	input encoder_pkg::frame_kind_t frame_kind [encoder_pkg::NUM_CH],
	input logic [31:0] frame_start [encoder_pkg::NUM_CH],
	output logic [encoder_pkg::NUM_CH-1:0] frame_ack,
	input logic decode_busy,
	input logic cfg_done,
	output logic invol_req,
	input logic invol_grant,
	output logic [31:0] param_data,
	output logic param_write,
	output logic cmd_done
);
	import encoder_pkg::*;

	// Each word state names the word loaded at its clock edge.
	typedef enum logic [2:0] {
		FR_IDLE,
		FR_WAIT_GRANT,
		FR_START,
		FR_VALUE,
		FR_KIND,
		FR_RESPONSE
	} state_t;

	state_t state;
	ch_idx_t sel_ch;
	logic [31:0] start_q;
	sample_t value_q;
	frame_kind_t kind_q;
	logic rsp_done;

	// Fixed priority, lowest channel first.
	always_comb begin
		sel_ch = '0;
		for (int i = NUM_CH - 1; i >= 0; i--) begin
			if (frame_valid[i]) begin
				sel_ch = ch_idx_t'(i);
			end
		end
	end

	assign cmd_done = rsp_done || cfg_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FR_IDLE;
			invol_req <= 1'b0;
			param_write <= 1'b0;
			rsp_done <= 1'b0;
			frame_ack <= '0;
		end else begin
			frame_ack <= '0;
			rsp_done <= 1'b0;
			case (state)
				FR_IDLE: begin
					if ((|frame_valid) && !decode_busy) begin
						invol_req <= 1'b1;
						state <= FR_WAIT_GRANT;
					end
				end
				FR_WAIT_GRANT: begin
					if (invol_grant) begin
						invol_req <= 1'b0;
						param_write <= 1'b1;
						frame_ack[sel_ch] <= 1'b1;
						state <= FR_START;
					end
				end
				FR_START: state <= FR_VALUE;
				FR_VALUE: state <= FR_KIND;
				FR_KIND: state <= FR_RESPONSE;
				FR_RESPONSE: begin
					param_write <= 1'b0;
					rsp_done <= 1'b1;
					state <= FR_IDLE;
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

	// The chosen frame is copied at grant so the reader may refill at once.
	always_ff @(posedge clk) begin
		case (state)
			FR_WAIT_GRANT: begin
				if (invol_grant) begin
					start_q <= frame_start[sel_ch];
					value_q <= frame_value[sel_ch];
					kind_q <= frame_kind[sel_ch];
					param_data <= 32'(sel_ch);
				end
			end
			FR_START: param_data <= start_q;
			FR_VALUE: param_data <= 32'(value_q);
			FR_KIND: param_data <= 32'(kind_q);
			FR_RESPONSE: param_data <= RSP_ENCODER_DATA;
			default: ;
		endcase
	end

	a_no_write_during_request: assert property (
		@(posedge clk) disable iff (reset) !(param_write && invol_req)
	) else $error("report_framer: parameter write while requesting the bus");

endmodule

// File: design/encoder_hub.sv
`timescale 1ns/1ps

module encoder_hub (
	input logic clk,
	input logic reset,
	input logic [31:0] systime,
	input logic [31:0] arg_data,
	input logic [encoder_pkg::CMD_BITS-1:0] cmd,
	input logic cmd_ready,
	output logic cmd_done,
	output logic [31:0] param_data,
	output logic param_write,
	output logic invol_req,
	input logic invol_grant,
	output logic [encoder_pkg::NUM_CH-1:0] enc_clk,
	output logic [encoder_pkg::NUM_CH-1:0] enc_cs,
	input logic [encoder_pkg::NUM_CH-1:0] enc_do
);
	import encoder_pkg::*;

	logic cfg_write;
	ch_idx_t cfg_ch;
	div_t cfg_div;
	logic [31:0] cfg_data_int;
	logic [31:0] cfg_mag_int;
	logic [31:0] cfg_time;
	logic cfg_done;
	logic decode_busy;
	logic [NUM_CH-1:0] frame_valid;
	sample_t frame_value [NUM_CH];
	frame_kind_t frame_kind [NUM_CH];
	logic [31:0] frame_start [NUM_CH];
	logic [NUM_CH-1:0] frame_ack;

	cmd_decode u_decode (
		.clk(clk),
		.reset(reset),
		.systime(systime),
		.arg_data(arg_data),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.cfg_write(cfg_write),
		.cfg_ch(cfg_ch),
		.cfg_div(cfg_div),
		.cfg_data_int(cfg_data_int),
		.cfg_mag_int(cfg_mag_int),
		.cfg_time(cfg_time),
		.cfg_done(cfg_done),
		.decode_busy(decode_busy)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_reader
		ssi_reader #(
			.CH(ch_idx_t'(i))
		) u_reader (
			.clk(clk),
			.reset(reset),
			.systime(systime),
			.cfg_write(cfg_write),
			.cfg_ch(cfg_ch),
			.cfg_div(cfg_div),
			.cfg_data_int(cfg_data_int),
			.cfg_mag_int(cfg_mag_int),
			.cfg_time(cfg_time),
			.enc_do(enc_do[i]),
			.enc_clk(enc_clk[i]),
			.enc_cs(enc_cs[i]),
			.frame_valid(frame_valid[i]),
			.frame_value(frame_value[i]),
			.frame_kind(frame_kind[i]),
			.frame_start(frame_start[i]),
			.frame_ack(frame_ack[i])
		);
	end

	report_framer u_framer (
		.clk(clk),
		.reset(reset),
		.frame_valid(frame_valid),
		.frame_value(frame_value),
		.frame_kind(frame_kind),
		.frame_start(frame_start),
		.frame_ack(frame_ack),
		.decode_busy(decode_busy),
		.cfg_done(cfg_done),
		.invol_req(invol_req),
		.invol_grant(invol_grant),
		.param_data(param_data),
		.param_write(param_write),
		.cmd_done(cmd_done)
	);

endmodule

// File: verif/encoder_sensor_model.sv
`timescale 1ns/1ps

module encoder_sensor_model (
	input logic enc_clk,
	input logic enc_cs,
	input encoder_pkg::sample_t value,
	output logic enc_do
);
	import encoder_pkg::*;

	sample_t shift;
	logic first_edge;

	initial begin
		shift = '1;
		first_edge = 1'b0;
		enc_do = 1'b1;
	end

	// The frame is latched as chip select falls and the MSB goes out at once.
	always @(negedge enc_cs) begin
		shift = value;
		first_edge = 1'b1;
		enc_do = value[SAMPLE_BITS-1];
	end

	// The first falling clock edge holds the MSB, later edges move to the next bit.
	always @(negedge enc_clk) begin
		if (!enc_cs) begin
			if (first_edge) begin
				first_edge = 1'b0;
			end else begin
				shift = {shift[SAMPLE_BITS-2:0], 1'b0};
			end
			enc_do = shift[SAMPLE_BITS-1];
		end
	end

endmodule

// File: verif/encoder_hub_tb.sv
`timescale 1ns/1ps

module encoder_hub_tb;
	import encoder_pkg::*;

	typedef struct packed {
		ch_idx_t ch;
		div_t div;
		logic [31:0] data_int;
		logic [31:0] mag_int;
		logic do_config;
		logic new_value;
		logic exp_report;
		logic pair;
		logic quiet_pins;
		logic [15:0] hold;
	} step_t;

	localparam int NUM_STEPS = 6;

	logic clk;
	logic reset;
	logic [31:0] systime;
	logic [31:0] arg_data;
	logic [CMD_BITS-1:0] cmd;
	logic cmd_ready;
	logic cmd_done;
	logic [31:0] param_data;
	logic param_write;
	logic invol_req;
	logic invol_grant;
	logic [NUM_CH-1:0] enc_clk;
	logic [NUM_CH-1:0] enc_cs;
	logic [NUM_CH-1:0] enc_do;

	sample_t sensor_value [NUM_CH];
	step_t steps [NUM_STEPS];
	string step_name [NUM_STEPS];
	logic [31:0] sched_base [NUM_CH];
	logic [31:0] sched_int [NUM_CH];
	frame_kind_t ch_kind [NUM_CH];
	logic [31:0] lfsr_state;
	logic [31:0] cfg_time_seen;
	int error_count;
	int tests_run;

	encoder_hub UUT (
		.clk(clk),
		.reset(reset),
		.systime(systime),
		.arg_data(arg_data),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.cmd_done(cmd_done),
		.param_data(param_data),
		.param_write(param_write),
		.invol_req(invol_req),
		.invol_grant(invol_grant),
		.enc_clk(enc_clk),
		.enc_cs(enc_cs),
		.enc_do(enc_do)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_sensor
		encoder_sensor_model u_sensor (
			.enc_clk(enc_clk[i]),
			.enc_cs(enc_cs[i]),
			.value(sensor_value[i]),
			.enc_do(enc_do[i])
		);
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		systime <= systime + 1;
	end

	// Galois LFSR stepped once per bit taken.
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// A new value must differ from the last one and from the reset value.
	function automatic sample_t fresh_value(sample_t old);
		sample_t v;
		int tries;
		tries = 0;
		v = sample_t'(random_bits(SAMPLE_BITS));
		while ((v == old || v == '1) && tries < 16) begin
			v = sample_t'(random_bits(SAMPLE_BITS));
			tries++;
		end
		return v;
	endfunction

	// Start time of the first frame whose chip select falls after this cycle's value change.
	function automatic logic [31:0] next_start(ch_idx_t ch);
		logic [31:0] k;
		k = (systime - 1 - sched_base[ch] + sched_int[ch] - 1) / sched_int[ch];
		if (k == 0) begin
			k = 1;
		end
		return sched_base[ch] + k * sched_int[ch] + 1;
	endfunction

	task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_kind(string what, frame_kind_t got, frame_kind_t exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic stop_on_timeout(string what);
		error_count++;
		$display("error at %0t ns: %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic issue_command(logic [CMD_BITS-1:0] code, ch_idx_t ch, logic [31:0] w0,
			logic [31:0] w1, logic [31:0] w2, int nwords, int exp_latency);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		cmd = code;
		cmd_ready = 1'b1;
		arg_data = 32'(ch);
		while (n < 20) begin
			@(negedge clk);
			if (param_write) begin
				error_count++;
				$display("error at %0t ns: parameter write during a command", $time);
			end
			// Cycle 2 carries the data interval word.
			if (n == 2) begin
				cfg_time_seen = systime;
			end
			if (cmd_done) begin
				break;
			end
			@(posedge clk);
			#1;
			cmd_ready = 1'b0;
			arg_data = (n == 0 && nwords > 0) ? w0 : (n == 1 && nwords > 1) ? w1 :
				(n == 2 && nwords > 2) ? w2 : 32'h0;
			n++;
		end
		if (!cmd_done) begin
			stop_on_timeout("no cmd_done for a command");
		end else begin
			check_word("cmd_done latency", 32'(n), 32'(exp_latency));
		end
		@(posedge clk);
		#1;
		cmd_ready = 1'b0;
		arg_data = '0;
	endtask

	task automatic collect_report(ch_idx_t exp_ch, logic [31:0] exp_start, sample_t exp_value,
			frame_kind_t exp_kind, int hold);
		int n;
		int delay;
		n = 0;
		while (!invol_req && n < 4000) begin
			@(negedge clk);
			n++;
		end
		if (!invol_req) begin
			stop_on_timeout("no report request from the DUT");
		end
		delay = (hold > 0) ? hold : 1 + int'(random_bits(2));
		repeat (delay) @(posedge clk);
		#1;
		invol_grant = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (invol_req && n < 10);
		if (invol_req) begin
			stop_on_timeout("request still high after grant");
		end
		check_word("param_write on channel word", 32'(param_write), 32'd1);
		check_word("channel word", param_data, 32'(exp_ch));
		@(posedge clk);
		#1;
		invol_grant = 1'b0;
		@(negedge clk);
		check_word("start word", param_data, exp_start);
		@(negedge clk);
		check_word("value word", param_data, 32'(exp_value));
		@(negedge clk);
		check_word("param_write on kind word", 32'(param_write), 32'd1);
		check_word("kind word", param_data, 32'(exp_kind));
		check_kind("frame kind", frame_kind_t'(param_data[0]), exp_kind);
		@(negedge clk);
		check_word("param_write after report", 32'(param_write), 32'd0);
		check_word("response code", param_data, RSP_ENCODER_DATA);
		check_word("cmd_done after report", 32'(cmd_done), 32'd1);
	endtask

	task automatic watch_quiet(int cycles, ch_idx_t ch, logic check_pins);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (invol_req) begin
				error_count++;
				$display("error at %0t ns: unexpected report request", $time);
				break;
			end
			if (check_pins && (enc_clk[ch] !== 1'b1 || enc_cs[ch] !== 1'b1)) begin
				error_count++;
				$display("error at %0t ns: disabled channel moved its serial lines", $time);
				break;
			end
		end
	endtask

	// ch, div, data_int, mag_int, config, new value, report, pair, pins, grant hold.
	task automatic build_steps();
		steps[0] = '{1'b0, 12'd2, 32'd300, 32'd0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 16'd0};
		steps[1] = '{1'b0, 12'd2, 32'd300, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0};
		steps[2] = '{1'b0, 12'd2, 32'd300, 32'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 16'd0};
		steps[3] = '{1'b0, 12'd2, 32'd0, 32'd250, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 16'd0};
		steps[4] = '{1'b1, 12'd0, 32'd100, 32'd0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'd0};
		steps[5] = '{1'b1, 12'd3, 32'd400, 32'd0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 16'd700};
		step_name[0] = "first position report";
		step_name[1] = "repeated value filtered";
		step_name[2] = "changed value reported";
		step_name[3] = "magnet only";
		step_name[4] = "disabled channel";
		step_name[5] = "two channels, late grant";
	endtask

	initial begin
		step_t s;
		int errs;
		logic [31:0] exp_start;
		logic [31:0] pair_start;
		lfsr_state = 32'hd073;
		error_count = 0;
		tests_run = 0;
		reset = 1'b1;
		systime = '0;
		arg_data = '0;
		cmd = '0;
		cmd_ready = 1'b0;
		invol_grant = 1'b0;
		cfg_time_seen = '0;
		for (int c = 0; c < NUM_CH; c++) begin
			sensor_value[c] = '1;
			sched_base[c] = '0;
			sched_int[c] = 32'd1;
			ch_kind[c] = KIND_POSITION;
		end
		build_steps();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		tests_run++;
		errs = error_count;
		issue_command(8'h13, '0, '0, '0, '0, 0, 1);
		$display("test 0 unknown command: %s", (error_count == errs) ? "ok" : "FAILED");

		for (int i = 0; i < NUM_STEPS; i++) begin
			s = steps[i];
			tests_run++;
			errs = error_count;
			if (s.do_config) begin
				issue_command(CMD_CONFIG_ENCODER, s.ch, 32'(s.div), s.data_int, s.mag_int, 3, 4);
				sched_base[s.ch] = cfg_time_seen;
				sched_int[s.ch] = (s.data_int != 0) ? s.data_int : s.mag_int;
				ch_kind[s.ch] = (s.data_int != 0) ? KIND_POSITION : KIND_MAGNET;
			end
			@(posedge clk);
			#1;
			if (s.new_value) begin
				sensor_value[s.ch] = fresh_value(sensor_value[s.ch]);
			end
			if (s.pair) begin
				sensor_value[0] = fresh_value(sensor_value[0]);
			end
			@(negedge clk);
			exp_start = s.do_config ? sched_base[s.ch] + sched_int[s.ch] + 1 : next_start(s.ch);
			pair_start = next_start('0);
			if (s.exp_report && s.pair) begin
				collect_report('0, pair_start, sensor_value[0], ch_kind[0], int'(s.hold));
				collect_report(s.ch, exp_start, sensor_value[s.ch], ch_kind[s.ch], 0);
				watch_quiet(100, s.ch, 1'b0);
			end else if (s.exp_report) begin
				collect_report(s.ch, exp_start, sensor_value[s.ch], ch_kind[s.ch], int'(s.hold));
				watch_quiet(100, s.ch, 1'b0);
			end else begin
				watch_quiet(2 * int'(sched_int[s.ch]) + 50, s.ch, s.quiet_pins);
			end
			$display("test %0d %s: %s", i + 1, step_name[i],
				(error_count == errs) ? "ok" : "FAILED");
		end

		$display("tests run %0d, errors %0d", tests_run, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: encoder_hub.f
design/encoder_pkg.sv
design/cmd_decode.sv
design/ssi_reader.sv
design/report_framer.sv
design/encoder_hub.sv
verif/encoder_sensor_model.sv
verif/encoder_hub_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module encoder_hub_tb \
	-f encoder_hub.f \
	--Mdir obj_dir -o sim_encoder_hub

./obj_dir/sim_encoder_hub > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
